// File: dv/tb_mist_io.sv
// testbench for the mist i/o shell that drives spi, events and video and is built from src.f
`timescale 1ns/1ps
`include "mist_io_macros.svh"

module tb_mist_io;

  logic                    clk_28;
  logic                    reset;
  logic                    spi_sck;
  logic                    spi_mosi;
  logic                    conf_data0;
  logic                    kms_ready;
  mist_io_pkg::rgb_t       rgb;
  logic                    hs_n;
  logic                    vs_n;
  logic                    spi_miso;
  logic                    spi_miso_oe;
  logic [7:0]              joya;
  logic [7:0]              joyb;
  logic [2:0]              mouse_buttons;
  mist_io_pkg::core_cfg_t  core_cfg;
  mist_io_pkg::kms_event_t kms;
  logic                    kms_valid;
  mist_io_pkg::vga_t       vga;

  logic [31:0] stim_lfsr;                // main stimulus sequence
  logic [31:0] ready_lfsr = 32'hf179;    // own sequence for the ready toggler
  int          ready_mode;               // 0 low, 1 high, 2 random
  int          err_count;
  logic [9:0]  exp_q[$];                 // expected events as {kind, data}
  logic [7:0]  exp_joya;
  logic [7:0]  exp_joyb;
  logic [2:0]  exp_buttons;
  logic [3:0]  exp_cfg;
  logic [7:0]  pay [16];                 // payload of the next command
  logic        stalled = 1'b0;           // last negedge saw valid without ready
  logic [9:0]  held_kms;

  mist_io_top uut (
    .clk_28(clk_28), .reset(reset), .spi_sck(spi_sck), .spi_mosi(spi_mosi),
    .conf_data0(conf_data0), .kms_ready(kms_ready), .rgb(rgb), .hs_n(hs_n), .vs_n(vs_n),
    .spi_miso(spi_miso), .spi_miso_oe(spi_miso_oe), .joya(joya), .joyb(joyb),
    .mouse_buttons(mouse_buttons), .core_cfg(core_cfg), .kms(kms), .kms_valid(kms_valid),
    .vga(vga)
  );

  initial begin
    clk_28 = 1'b0;
    forever #10 clk_28 = ~clk_28;        // 20 ns period
  end

  ////////////////////////////////////////
  // random numbers and checks
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // right shifting galois step
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);  // one step per bit
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    err_count++;
    $display("ERROR at %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////
  // spi host
  ////////////////////////////////////////
  task automatic spi_xfer(input logic [7:0] tx, input logic push, input logic [9:0] ev,
                          output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk_28);
      spi_sck  <= 1'b0;
      spi_mosi <= tx[i];                 // msb first while sck low
      repeat (4) @(posedge clk_28);
      @(negedge clk_28);
      rx[i] = spi_miso;                  // settled since the last falling edge
      @(posedge clk_28);
      spi_sck <= 1'b1;
      repeat (4) @(posedge clk_28);
    end
    if (push && exp_q.size() < `KMS_DEPTH) exp_q.push_back(ev);  // full queue drops
  endtask

  task automatic open_select();
    @(posedge clk_28);
    conf_data0 <= 1'b0;
    repeat (5) @(posedge clk_28);        // id byte loads on select fall
    @(negedge clk_28);
    check_value("spi_miso_oe in window", 32'(1'b1), 32'(spi_miso_oe));
  endtask

  task automatic close_select();
    @(posedge clk_28);
    spi_sck <= 1'b0;
    repeat (4) @(posedge clk_28);
    conf_data0 <= 1'b1;
    repeat (6) @(posedge clk_28);
    @(negedge clk_28);
    check_value("spi_miso_oe after window", 32'(1'b0), 32'(spi_miso_oe));
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  task automatic model_payload(input logic [7:0] cmd, input int idx, input logic [7:0] data,
                               output logic push, output logic [9:0] ev);
    push = 1'b0;
    ev   = '0;
    case (cmd)
      `CMD_JOY0:   exp_joya = data;
      `CMD_JOY1:   exp_joyb = data;
      `CMD_CONFIG: exp_cfg = data[3:0];  // low nibble only
      `CMD_MOUSE: begin
        if (idx == 0) exp_buttons = data[2:0];
        if (idx == 1 || idx == 2) begin
          push = 1'b1;
          ev   = (idx == 1) ? {mist_io_pkg::KMS_MOUSE_X, data} : {mist_io_pkg::KMS_MOUSE_Y, data};
        end
      end
      `CMD_KEY: begin
        push = 1'b1;
        ev   = {mist_io_pkg::KMS_KEY, data};
      end
      default: ;                         // unknown command has no effect
    endcase
  endtask

  function automatic int clamp_byte(input int v);
    if (v < 0) return 0;
    if (v > 255) return 255;
    return v;
  endfunction

  function automatic logic [19:0] video_model(input logic [23:0] c, input logic hs,
                                             input logic vs, input logic ypbpr);
    int r;
    int g;
    int b;
    int y;
    int pb;
    int pr;
    r = int'(c[23:16]);
    g = int'(c[15:8]);
    b = int'(c[7:0]);
    if (!ypbpr) return {hs, vs, c[23:18], c[15:10], c[7:2]};  // plain rgb keeps the top bits
    y  = (`Y_R * r + `Y_G * g + `Y_B * b) >>> 8;
    pb = clamp_byte(((`PB_R * r + `PB_G * g + `PB_B * b) >>> 8) + 128);
    pr = clamp_byte(((`PR_R * r + `PR_G * g + `PR_B * b) >>> 8) + 128);
    return {hs & vs, 1'b1, 6'(pr >> 2), 6'(y >> 2), 6'(pb >> 2)};  // csync on hs
  endfunction

  ////////////////////////////////////////
  // command level helpers
  ////////////////////////////////////////
  task automatic send_cmd(input logic [7:0] cmd, input int n);
    logic [7:0] rx;
    logic       push;
    logic [9:0] ev;
    open_select();
    spi_xfer(cmd, 1'b0, '0, rx);
    check_value("spi_miso id byte", 32'(`CORE_ID), 32'(rx));
    for (int k = 0; k < n; k++) begin
      model_payload(cmd, k, pay[k], push, ev);
      spi_xfer(pay[k], push, ev, rx);
      check_value("spi_miso payload byte", 32'(8'h00), 32'(rx));
    end
    close_select();
  endtask

  task automatic check_regs();
    @(negedge clk_28);
    check_value("joya", 32'(exp_joya), 32'(joya));
    check_value("joyb", 32'(exp_joyb), 32'(joyb));
    check_value("mouse_buttons", 32'(exp_buttons), 32'(mouse_buttons));
    check_value("core_cfg", 32'(exp_cfg), 32'(core_cfg));
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || kms_valid) begin
      @(negedge clk_28);
      n++;
      if (n > limit) report_failure("the expected events never came out of the queue");
    end
  endtask

  // ready toggler on its own lfsr
  always @(posedge clk_28) begin
    if (ready_mode == 2) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      kms_ready <= ready_lfsr[0];
    end else begin
      kms_ready <= (ready_mode == 1);
    end
  end

  // event monitor samples handshake and stall hold at negedge
  always @(negedge clk_28) begin
    if (!reset) begin
      if (stalled) check_value("kms held", 32'(held_kms), 32'(kms));
      if (kms_valid && kms_ready) begin
        if (exp_q.size() == 0) report_failure("an event came out that was never sent");
        else check_value("kms", 32'(exp_q.pop_front()), 32'(kms));
      end
      stalled  = kms_valid && !kms_ready;
      held_kms = kms;
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    int          sel;
    int          n;
    logic [7:0]  cmd;
    logic [23:0] v_rgb;
    logic        v_hs;
    logic        v_vs;
    logic [25:0] hist[$];               // {rgb, hs, vs} per driven cycle
    stim_lfsr  = 32'hf179;
    err_count  = 0;
    exp_joya   = '0;
    exp_joyb   = '0;
    exp_buttons = '0;
    exp_cfg    = '0;
    reset      = 1'b1;
    spi_sck    = 1'b0;
    spi_mosi   = 1'b0;
    conf_data0 = 1'b1;                   // deselected
    kms_ready  = 1'b0;
    ready_mode = 0;
    rgb        = '0;
    hs_n       = 1'b1;
    vs_n       = 1'b1;
    repeat (3) @(posedge clk_28);
    reset <= 1'b0;

    @(negedge clk_28);                   // state right after reset
    check_value("kms_valid", 32'(1'b0), 32'(kms_valid));
    check_value("spi_miso_oe", 32'(1'b0), 32'(spi_miso_oe));
    check_regs();

    // random commands with ready toggling
    @(posedge clk_28);
    ready_mode <= 2;
    for (int c = 0; c < 40; c++) begin
      sel = int'(rand_bits(3));
      n   = 1 + int'(rand_bits(2));
      case (sel)
        0: cmd = `CMD_JOY0;
        1: cmd = `CMD_JOY1;
        2: cmd = `CMD_CONFIG;
        3: cmd = `CMD_MOUSE;
        4: cmd = 8'h30;                  // unknown command
        default: cmd = `CMD_KEY;
      endcase
      if (cmd == `CMD_MOUSE) n = 3;
      for (int k = 0; k < n; k++) pay[k] = 8'(rand_bits(8));
      send_cmd(cmd, n);
      check_regs();
    end
    wait_drain(400);

    // full queue drops the later codes
    @(posedge clk_28);
    ready_mode <= 0;
    repeat (3) @(posedge clk_28);
    for (int k = 0; k < `KMS_DEPTH + 2; k++) pay[k] = 8'(rand_bits(8));
    send_cmd(`CMD_KEY, `KMS_DEPTH + 2);
    @(posedge clk_28);
    ready_mode <= 1;
    wait_drain(100);
    repeat (50) begin
      @(negedge clk_28);
      check_value("kms_valid after drain", 32'(1'b0), 32'(kms_valid));
    end

    // video in rgb then ypbpr mode
    for (int m = 0; m < 2; m++) begin
      pay[0]    = 8'(rand_bits(8));
      pay[0][1] = (m == 1);             // ypbpr bit
      send_cmd(`CMD_CONFIG, 1);
      check_regs();
      hist.delete();
      for (int t = 0; t < 200; t++) begin
        @(posedge clk_28);
        v_rgb = 24'(rand_bits(24));
        v_hs  = rand_bits(1) != 0;
        v_vs  = rand_bits(1) != 0;
        rgb  <= v_rgb;
        hs_n <= v_hs;
        vs_n <= v_vs;
        hist.push_back({v_rgb, v_hs, v_vs});
        @(negedge clk_28);
        if (hist.size() == 3) begin     // output of two cycles back
          check_value("vga", 32'(video_model(hist[0][25:2], hist[0][1], hist[0][0], m == 1)),
                      32'(vga));
          hist.delete(0);
        end
      end
    end

    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mist_io -o tb_mist_io_sim

./obj_dir/tb_mist_io_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: src.f
+incdir+verilog
verilog/mist_io_pkg.sv
verilog/spi_frontend.sv
verilog/user_io_decoder.sv
verilog/kms_fifo.sv
verilog/video_out_stage.sv
verilog/mist_io_top.sv
dv/tb_mist_io.sv

// File: verilog/kms_fifo.sv
// keyboard and mouse event queue that drops new events when full and drains over valid/ready
`timescale 1ns/1ps
`include "mist_io_macros.svh"

module kms_fifo #(
  parameter int KMS_DEPTH = `KMS_DEPTH   // power of two
) (
  input  logic                    clk_28,
  input  logic                    reset,
  input  mist_io_pkg::kms_event_t ev,
  input  logic                    ev_push,
  input  logic                    kms_ready,
  output mist_io_pkg::kms_event_t kms,
  output logic                    kms_valid
);

  localparam int AW = $clog2(KMS_DEPTH);

  mist_io_pkg::kms_event_t mem [KMS_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_en;    // push that fits
  logic          rd_en;    // handshake

  assign wr_en = ev_push && (count != (AW+1)'(KMS_DEPTH));
  assign rd_en = kms_valid && kms_ready;

  always_ff @(posedge clk_28) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + AW'(1);    // wraps at depth
      if (rd_en) rd_ptr <= rd_ptr + AW'(1);
      count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
    end
  end

  always_ff @(posedge clk_28) begin
    if (wr_en) mem[wr_ptr] <= ev;
  end

  assign kms       = mem[rd_ptr];              // head entry
  assign kms_valid = (count != '0);

  a_hold_stable : assert property (@(posedge clk_28) disable iff (reset)
    kms_valid && !kms_ready |=> $stable(kms))
    else $error("kms changed while stalled");

endmodule

// File: verilog/mist_io_macros.svh
// shared constants for the mist i/o shell, include wherever a command code or width is needed
`ifndef MIST_IO_MACROS_SVH
`define MIST_IO_MACROS_SVH

`define CMD_JOY0    8'h02   // joystick port 0, one byte
`define CMD_JOY1    8'h03   // joystick port 1, one byte
`define CMD_MOUSE   8'h04   // buttons, dx, dy
`define CMD_KEY     8'h05   // any number of key codes
`define CMD_CONFIG  8'h15   // low nibble is core config
`define CORE_ID     8'ha5   // aga core id
`define KMS_DEPTH   8       // event queue entries
`define RGB_W       8       // core colour width
`define VGA_W       6       // vga dac width
`define Y_R         77      // luma weights, sum is 256
`define Y_G         150
`define Y_B         29
`define PB_R        (-43)   // blue difference weights
`define PB_G        (-85)
`define PB_B        128
`define PR_R        128     // red difference weights
`define PR_G        (-107)
`define PR_B        (-21)
`endif

// File: verilog/mist_io_pkg.sv
// shared types for the mist i/o shell, referenced by scoped name from every module
`include "mist_io_macros.svh"

package mist_io_pkg;

  typedef struct packed {
    logic       first;  // first byte since select fell
    logic [7:0] data;   // byte as shifted in, msb first
  } spi_byte_t;

  typedef enum logic [1:0] {
    KMS_MOUSE_X = 2'd0,
    KMS_MOUSE_Y = 2'd1,
    KMS_KEY     = 2'd2
  } kms_type_e;

  typedef struct packed {
    kms_type_e  kind;   // what the data byte means
    logic [7:0] data;   // key code or mouse delta
  } kms_event_t;

  typedef struct packed {
    logic [1:0] spare;
    logic       ypbpr;            // component output on vga port
    logic       scandoubler_off;  // 15khz video
  } core_cfg_t;

  typedef struct packed {
    logic [`RGB_W-1:0] r;
    logic [`RGB_W-1:0] g;
    logic [`RGB_W-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic              hs;  // active low
    logic              vs;  // active low
    logic [`VGA_W-1:0] r;
    logic [`VGA_W-1:0] g;
    logic [`VGA_W-1:0] b;
  } vga_t;

endpackage

// File: verilog/mist_io_top.sv
// mist i/o shell top, connects spi frontend, command decoder, event queue and video stage
`timescale 1ns/1ps
`include "mist_io_macros.svh"

module mist_io_top (
  input  logic                    clk_28,
  input  logic                    reset,
  input  logic                    spi_sck,
  input  logic                    spi_mosi,
  input  logic                    conf_data0,   // user_io select
  input  logic                    kms_ready,
  input  mist_io_pkg::rgb_t       rgb,
  input  logic                    hs_n,
  input  logic                    vs_n,
  output logic                    spi_miso,
  output logic                    spi_miso_oe,
  output logic [7:0]              joya,
  output logic [7:0]              joyb,
  output logic [2:0]              mouse_buttons,
  output mist_io_pkg::core_cfg_t  core_cfg,
  output mist_io_pkg::kms_event_t kms,
  output logic                    kms_valid,
  output mist_io_pkg::vga_t       vga
);

  mist_io_pkg::spi_byte_t  rx_byte;
  logic                    rx_valid;
  logic [7:0]              tx_byte;   // reply for the next byte
  mist_io_pkg::kms_event_t ev;
  logic                    ev_push;

  ////////////////////////////////////////
  // host spi path
  ////////////////////////////////////////
  spi_frontend u_spi (
    .clk_28     (clk_28     ),
    .reset      (reset      ),
    .spi_sck    (spi_sck    ),
    .spi_mosi   (spi_mosi   ),
    .conf_data0 (conf_data0 ),
    .tx_byte    (tx_byte    ),
    .spi_miso   (spi_miso   ),
    .spi_miso_oe(spi_miso_oe),
    .rx_byte    (rx_byte    ),
    .rx_valid   (rx_valid   )
  );

  user_io_decoder u_dec (
    .clk_28       (clk_28       ),
    .reset        (reset        ),
    .rx_byte      (rx_byte      ),
    .rx_valid     (rx_valid     ),
    .tx_byte      (tx_byte      ),
    .joya         (joya         ),
    .joyb         (joyb         ),
    .mouse_buttons(mouse_buttons),
    .core_cfg     (core_cfg     ),
    .ev           (ev           ),
    .ev_push      (ev_push      )
  );

  kms_fifo #(.KMS_DEPTH(`KMS_DEPTH)) u_kms (
    .clk_28   (clk_28   ),
    .reset    (reset    ),
    .ev       (ev       ),
    .ev_push  (ev_push  ),
    .kms_ready(kms_ready),
    .kms      (kms      ),
    .kms_valid(kms_valid)
  );

  ////////////////////////////////////////
  // video path, fixed 2 cycles
  ////////////////////////////////////////
  video_out_stage u_vid (
    .clk_28  (clk_28  ),
    .reset   (reset   ),
    .rgb     (rgb     ),
    .hs_n    (hs_n    ),
    .vs_n    (vs_n    ),
    .core_cfg(core_cfg),
    .vga     (vga     )
  );

endmodule

// File: verilog/spi_frontend.sv
// host spi slave in the clk_28 domain, delivers received bytes and shifts the reply byte out
`timescale 1ns/1ps

module spi_frontend (
  input  logic                  clk_28,
  input  logic                  reset,
  input  logic                  spi_sck,
  input  logic                  spi_mosi,
  input  logic                  conf_data0,   // active low select
  input  logic [7:0]            tx_byte,
  output logic                  spi_miso,
  output logic                  spi_miso_oe,
  output mist_io_pkg::spi_byte_t rx_byte,
  output logic                  rx_valid
);

  logic [2:0] sck_q;    // two sync flops plus edge history
  logic [1:0] mosi_q;   // lines up with sck_q[1]
  logic [2:0] ss_q;
  logic       ss_n;     // synchronized select
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_sr;
  logic [7:0] rx_data;
  logic [7:0] tx_sr;
  logic       first_q;  // window still at its command byte

  ////////////////////////////////////////
  // pin synchronizers and edges
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (reset) begin
      sck_q  <= '0;
      mosi_q <= '0;
      ss_q   <= '1;     // deselected
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck};
      mosi_q <= {mosi_q[0], spi_mosi};
      ss_q   <= {ss_q[1:0], conf_data0};
    end
  end

  assign ss_n     = ss_q[1];
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_fall  = ss_q[2] & ~ss_q[1];

  ////////////////////////////////////////
  // receive side
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (reset) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      first_q  <= 1'b1;
    end else begin
      rx_valid <= 1'b0;
      if (ss_n) begin
        bit_cnt <= '0;                         // realign on every window
        first_q <= 1'b1;
      end else begin
        if (rx_valid) first_q <= 1'b0;         // drops after the command byte
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_28) begin
    if (sck_rise && !ss_n) begin
      rx_sr <= {rx_sr[5:0], mosi_q[1]};
      if (bit_cnt == 3'd7) rx_data <= {rx_sr, mosi_q[1]};  // eighth bit completes the byte
    end
  end

  assign rx_byte.first = first_q;
  assign rx_byte.data  = rx_data;

  ////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (ss_fall) begin
      tx_sr <= tx_byte;                        // msb ready before first rise
    end else if (sck_fall && !ss_n) begin
      tx_sr <= (bit_cnt == 3'd0) ? tx_byte : {tx_sr[6:0], 1'b0};
    end
  end

  assign spi_miso    = tx_sr[7];
  assign spi_miso_oe = ~ss_n;

  a_rx_in_window : assert property (@(posedge clk_28) disable iff (reset)
    rx_valid |-> !ss_n)
    else $error("rx_valid outside select window");

endmodule

// File: verilog/user_io_decoder.sv
// user_io command decoder that turns received spi bytes into control registers and kms events
`timescale 1ns/1ps
`include "mist_io_macros.svh"

module user_io_decoder (
  input  logic                   clk_28,
  input  logic                   reset,
  input  mist_io_pkg::spi_byte_t rx_byte,
  input  logic                   rx_valid,
  output logic [7:0]             tx_byte,
  output logic [7:0]             joya,
  output logic [7:0]             joyb,
  output logic [2:0]             mouse_buttons,
  output mist_io_pkg::core_cfg_t core_cfg,
  output mist_io_pkg::kms_event_t ev,
  output logic                   ev_push
);

  logic [7:0] cmd;      // current command of the window
  logic [1:0] idx;      // saturating payload byte index
  logic       payload;  // non-command byte arrived

  assign payload = rx_valid & ~rx_byte.first;

  // id only while the command byte is on the wire
  assign tx_byte = rx_byte.first ? `CORE_ID : 8'h00;

  ////////////////////////////////////////
  // command fsm and registers
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (reset) begin
      cmd           <= '0;
      idx           <= '0;
      joya          <= '0;
      joyb          <= '0;
      mouse_buttons <= '0;
      core_cfg      <= '0;
      ev_push       <= 1'b0;
    end else begin
      ev_push <= 1'b0;
      if (rx_valid && rx_byte.first) begin
        cmd <= rx_byte.data;                   // new command
        idx <= '0;
      end else if (payload) begin
        if (idx != 2'd3) idx <= idx + 2'd1;
        case (cmd)
          `CMD_JOY0:   joya <= rx_byte.data;
          `CMD_JOY1:   joyb <= rx_byte.data;
          `CMD_CONFIG: core_cfg <= mist_io_pkg::core_cfg_t'(rx_byte.data[3:0]);
          `CMD_MOUSE: begin
            if (idx == 2'd0) mouse_buttons <= rx_byte.data[2:0];
            if (idx == 2'd1 || idx == 2'd2) ev_push <= 1'b1;  // dx and dy
          end
          `CMD_KEY:    ev_push <= 1'b1;         // every byte is a key
          default: ;                            // unknown commands ignored
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // event payload
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (payload) begin
      ev.data <= rx_byte.data;
      if (cmd == `CMD_KEY) begin
        ev.kind <= mist_io_pkg::KMS_KEY;
      end else if (idx == 2'd1) begin
        ev.kind <= mist_io_pkg::KMS_MOUSE_X;
      end else begin
        ev.kind <= mist_io_pkg::KMS_MOUSE_Y;
      end
    end
  end

  // a push belongs to a single cycle byte pulse
  a_push_after_byte : assert property (@(posedge clk_28) disable iff (reset)
    ev_push |-> $past(rx_valid) && !rx_valid)
    else $error("event pushed without a single cycle byte pulse");

endmodule

// File: verilog/video_out_stage.sv
// two stage vga output, optional ypbpr matrix, 6 bit truncation and sync shaping
`timescale 1ns/1ps
`include "mist_io_macros.svh"

module video_out_stage (
  input  logic                   clk_28,
  input  logic                   reset,
  input  mist_io_pkg::rgb_t      rgb,
  input  logic                   hs_n,
  input  logic                   vs_n,
  input  mist_io_pkg::core_cfg_t core_cfg,
  output mist_io_pkg::vga_t      vga
);

  mist_io_pkg::rgb_t  rgb_q;
  logic signed [17:0] y_q;     // sums scaled by 256
  logic signed [17:0] pb_q;
  logic signed [17:0] pr_q;
  logic               ypbpr_q;
  logic               hs_q;
  logic               vs_q;
  logic [7:0]         pr_c;    // clamped pr
  logic [7:0]         pb_c;    // clamped pb

  // clamped back to 8 bits around the 128 offset
  function automatic logic [7:0] clamp_off(input logic signed [17:0] s);
    logic signed [10:0] v;
    v = 11'(s >>> 8) + 11'sd128;
    if (v < 0) return 8'd0;
    if (v > 255) return 8'd255;
    return v[7:0];
  endfunction

  assign pr_c = clamp_off(pr_q);
  assign pb_c = clamp_off(pb_q);

  ////////////////////////////////////////
  // stage 1 input register and matrix
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (reset) begin
      ypbpr_q <= 1'b0;
      hs_q    <= 1'b1;   // inactive
      vs_q    <= 1'b1;
    end else begin
      ypbpr_q <= core_cfg.ypbpr;
      hs_q    <= hs_n;
      vs_q    <= vs_n;
    end
  end

  always_ff @(posedge clk_28) begin
    rgb_q <= rgb;
    if (core_cfg.ypbpr) begin  // matrix idles in rgb mode
      y_q  <= 18'(`Y_R * rgb.r + `Y_G * rgb.g + `Y_B * rgb.b);
      pb_q <= 18'(`PB_R * $signed({1'b0, rgb.r}) + `PB_G * $signed({1'b0, rgb.g})
                  + `PB_B * $signed({1'b0, rgb.b}));
      pr_q <= 18'(`PR_R * $signed({1'b0, rgb.r}) + `PR_G * $signed({1'b0, rgb.g})
                  + `PR_B * $signed({1'b0, rgb.b}));
    end
  end

  ////////////////////////////////////////
  // stage 2 channel map and syncs
  ////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (reset) begin
      vga.hs <= 1'b1;
      vga.vs <= 1'b1;
    end else begin
      vga.hs <= ypbpr_q ? (hs_q & vs_q) : hs_q;  // composite sync on hs
      vga.vs <= ypbpr_q ? 1'b1 : vs_q;
    end
  end

  always_ff @(posedge clk_28) begin
    if (ypbpr_q) begin
      vga.r <= pr_c[7 -: `VGA_W];                // pr on red
      vga.g <= y_q[15 -: `VGA_W];                 // luma never exceeds 255
      vga.b <= pb_c[7 -: `VGA_W];                // pb on blue
    end else begin
      vga.r <= rgb_q.r[`RGB_W-1 -: `VGA_W];
      vga.g <= rgb_q.g[`RGB_W-1 -: `VGA_W];
      vga.b <= rgb_q.b[`RGB_W-1 -: `VGA_W];
    end
  end

endmodule
